// File: hdl/rvExec_defines.svh
`ifndef RVEXEC_DEFINES_SVH
`define RVEXEC_DEFINES_SVH

// register and data bus width
`define XLEN 64

`define ILEN 32

// byte address width on the APB side
`define PADDR_W 32

`endif

// File: hdl/rvExecPkg.sv
`default_nettype none

`include "rvExec_defines.svh"

package rvExecPkg;

    typedef enum logic [6:0] {
        LOAD      = 7'b0000011,
        STORE     = 7'b0100011,
        OP        = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_32     = 7'b0111011,
        OP_IMM_32 = 7'b0011011,
        LUI       = 7'b0110111,
        AUIPC     = 7'b0010111,
        JAL       = 7'b1101111,
        JALR      = 7'b1100111,
        BRANCH    = 7'b1100011
    } opcode_t;

    // load sizes, bit 2 selects zero extension
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LD  = 3'b011;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_LWU = 3'b110;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;
    localparam logic [2:0] F3_SD = 3'b011;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef struct packed {
        logic             en;
        logic [`XLEN-1:0] data;
    } wbWord_t;

    typedef struct packed {
        logic             taken;
        logic [`XLEN-1:0] target;
    } pcWord_t;

endpackage

`default_nettype wire

// File: hdl/immDecode.sv
`default_nettype none

`include "rvExec_defines.svh"

module immDecode
    import rvExecPkg::*;
(
    input  logic [`ILEN-1:0] inst,
    output opcode_t          opcode,
    output logic [2:0]       funct3,
    output logic [6:0]       funct7,
    output logic [4:0]       rd,
    output logic [`XLEN-1:0] immI,
    output logic [`XLEN-1:0] immS,
    output logic [`XLEN-1:0] immB,
    output logic [`XLEN-1:0] immU,
    output logic [`XLEN-1:0] immJ
);

    assign opcode = opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];

    // all immediates sign-extend from inst[31]
    assign immI = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign immS = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                   inst[11:8], 1'b0};
    assign immU = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign immJ = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                   inst[30:21], 1'b0};

endmodule

`default_nettype wire

// File: hdl/keyMux.sv
`default_nettype none

module keyMux #(
    parameter int  NUM_KEYS  = 2,
    parameter int  KEY_W     = 7,
    parameter type payload_t = logic
) (
    input  logic [KEY_W-1:0] key,
    input  logic [KEY_W-1:0] keys [NUM_KEYS],
    input  payload_t         payloads [NUM_KEYS],
    input  payload_t         dflt,
    output payload_t         out
);

    always_comb begin
        out = dflt;  // no key hit
        for (int i = 0; i < NUM_KEYS; i++) begin
            if (keys[i] == key) begin
                out = payloads[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/intAlu.sv
`default_nettype none

`include "rvExec_defines.svh"

module intAlu
    import rvExecPkg::*;
(
    input  opcode_t          opcode,
    input  logic [2:0]       funct3,
    input  logic [6:0]       funct7,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rs1Val,
    input  logic [`XLEN-1:0] rs2Val,
    input  logic [`XLEN-1:0] immI,
    input  logic [`XLEN-1:0] immU,
    output wbWord_t          wb
);

    localparam logic [6:0] WB_KEYS [8] = '{OP, OP_IMM, OP_32, OP_IMM_32,
                                           LUI, AUIPC, JAL, JALR};

    logic             isImm;
    logic             altOp;
    logic             subOp;
    logic             mulOp;
    logic [`XLEN-1:0] opB;
    logic [5:0]       shamt;
    logic [31:0]      a32;
    logic [31:0]      b32;
    logic [`XLEN-1:0] fullRes;
    logic             fullOk;
    logic [31:0]      word32;
    logic [`XLEN-1:0] wordRes;
    logic             wordOk;
    wbWord_t          wbCands [8];

    assign isImm = (opcode == OP_IMM) || (opcode == OP_IMM_32);
    assign opB   = isImm ? immI : rs2Val;
    assign shamt = opB[5:0];
    assign a32   = rs1Val[31:0];
    assign b32   = opB[31:0];
    assign altOp = funct7[5];  // inst[30], sub and sra
    assign subOp = altOp && !isImm;
    assign mulOp = (funct7 == 7'b0000001) && !isImm;

    always_comb begin
        fullRes = '0;
        case (funct3)
            3'b000: begin
                if (mulOp) fullRes = rs1Val * rs2Val;
                else if (subOp) fullRes = rs1Val - opB;
                else fullRes = rs1Val + opB;
            end
            3'b001: fullRes = rs1Val << shamt;
            3'b010: fullRes = {{(`XLEN-1){1'b0}}, $signed(rs1Val) < $signed(opB)};
            3'b011: fullRes = {{(`XLEN-1){1'b0}}, rs1Val < opB};
            3'b100: fullRes = rs1Val ^ opB;
            3'b101: begin
                if (altOp) fullRes = $signed(rs1Val) >>> shamt;
                else fullRes = rs1Val >> shamt;
            end
            3'b110: fullRes = rs1Val | opB;
            default: fullRes = rs1Val & opB;
        endcase
    end

    always_comb begin
        fullOk = 1'b0;
        if (isImm) begin
            case (funct3)
                3'b001: fullOk = (funct7[6:1] == 6'b000000);
                3'b101: fullOk = (funct7[6:1] == 6'b000000) || (funct7[6:1] == 6'b010000);
                default: fullOk = 1'b1;
            endcase
        end else begin
            case (funct7)
                7'b0000000: fullOk = 1'b1;
                7'b0100000: fullOk = (funct3 == 3'b000) || (funct3 == 3'b101);
                7'b0000001: fullOk = (funct3 == 3'b000);  // mul only
                default: fullOk = 1'b0;
            endcase
        end
    end

    // W forms work on the low word
    always_comb begin
        word32 = '0;
        wordOk = 1'b0;
        case (funct3)
            3'b000: begin
                wordOk = isImm || (funct7 == 7'b0000000) || (funct7 == 7'b0100000)
                         || (funct7 == 7'b0000001);
                if (mulOp) word32 = a32 * b32;
                else if (subOp) word32 = a32 - b32;
                else word32 = a32 + b32;
            end
            3'b001: begin
                wordOk = (funct7 == 7'b0000000);
                word32 = a32 << shamt[4:0];
            end
            3'b101: begin
                wordOk = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                if (altOp) word32 = $signed(a32) >>> shamt[4:0];
                else word32 = a32 >> shamt[4:0];
            end
            default: wordOk = 1'b0;
        endcase
    end

    assign wordRes = {{(`XLEN-32){word32[31]}}, word32};

    assign wbCands[0] = {fullOk, fullRes};
    assign wbCands[1] = {fullOk, fullRes};
    assign wbCands[2] = {wordOk, wordRes};
    assign wbCands[3] = {wordOk, wordRes};
    assign wbCands[4] = {1'b1, immU};
    assign wbCands[5] = {1'b1, pc + immU};
    assign wbCands[6] = {1'b1, pc + 4};  // link
    assign wbCands[7] = {funct3 == 3'b000, pc + 4};

    keyMux #(
        .NUM_KEYS (8),
        .KEY_W    (7),
        .payload_t(wbWord_t)
    ) u_wbMux (
        .key     (opcode),
        .keys    (WB_KEYS),
        .payloads(wbCands),
        .dflt    ('0),
        .out     (wb)
    );

endmodule

`default_nettype wire

// File: hdl/branchUnit.sv
`default_nettype none

`include "rvExec_defines.svh"

module branchUnit
    import rvExecPkg::*;
(
    input  opcode_t          opcode,
    input  logic [2:0]       funct3,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rs1Val,
    input  logic [`XLEN-1:0] rs2Val,
    input  logic [`XLEN-1:0] immB,
    input  logic [`XLEN-1:0] immJ,
    input  logic [`XLEN-1:0] immI,
    output pcWord_t          target
);

    localparam logic [6:0] PC_KEYS [3] = '{BRANCH, JAL, JALR};

    logic             brTaken;
    logic [`XLEN-1:0] seqPc;
    logic [`XLEN-1:0] jalrPc;
    pcWord_t          pcCands [3];

    always_comb begin
        brTaken = 1'b0;
        case (funct3)
            F3_BEQ:  brTaken = (rs1Val == rs2Val);
            F3_BNE:  brTaken = (rs1Val != rs2Val);
            F3_BLT:  brTaken = ($signed(rs1Val) < $signed(rs2Val));
            F3_BGE:  brTaken = ($signed(rs1Val) >= $signed(rs2Val));
            F3_BLTU: brTaken = (rs1Val < rs2Val);
            F3_BGEU: brTaken = (rs1Val >= rs2Val);
            default: brTaken = 1'b0;  // 010, 011 reserved
        endcase
    end

    assign seqPc  = pc + 4;
    assign jalrPc = (rs1Val + immI) & ~`XLEN'd1;  // clear bit 0

    assign pcCands[0] = {brTaken, brTaken ? pc + immB : seqPc};
    assign pcCands[1] = {1'b1, pc + immJ};
    assign pcCands[2] = {funct3 == 3'b000, jalrPc};

    keyMux #(
        .NUM_KEYS (3),
        .KEY_W    (7),
        .payload_t(pcWord_t)
    ) u_pcMux (
        .key     (opcode),
        .keys    (PC_KEYS),
        .payloads(pcCands),
        .dflt    ({1'b0, seqPc}),
        .out     (target)
    );

endmodule

`default_nettype wire

// File: hdl/lsuApb.sv
`default_nettype none

`include "rvExec_defines.svh"

module lsuApb
    import rvExecPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 start,
    input  logic                 isStore,
    input  logic [2:0]           funct3,
    input  logic [`XLEN-1:0]     addr,
    input  logic [`XLEN-1:0]     storeData,
    output logic                 done,
    output logic [`XLEN-1:0]     loadData,
    output logic [`PADDR_W-1:0]  paddr,
    output logic                 psel,
    output logic                 penable,
    output logic                 pwrite,
    output logic [`XLEN-1:0]     pwdata,
    output logic [`XLEN/8-1:0]   pstrb,
    input  logic [`XLEN-1:0]     prdata,
    input  logic                 pready
);

    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apbState_t;

    apbState_t          state;
    logic [2:0]         lane;
    logic [2:0]         loadFunct3;
    logic [`XLEN/8-1:0] sizeMask;
    logic [`XLEN-1:0]   laneData;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (start) state <= SETUP;
                SETUP:   state <= ACCESS;
                default: if (pready) state <= IDLE;  // completes on pready edge
            endcase
        end
    end

    always_comb begin
        case (funct3)
            F3_SB:   sizeMask = 8'h01;
            F3_SH:   sizeMask = 8'h03;
            F3_SW:   sizeMask = 8'h0f;
            F3_SD:   sizeMask = 8'hff;
            default: sizeMask = 8'h00;
        endcase
    end

    // request fields captured with the start pulse
    always_ff @(posedge clk) begin
        if (start) begin
            paddr      <= addr[`PADDR_W-1:0];
            pwrite     <= isStore;
            pwdata     <= storeData << {addr[2:0], 3'b000};
            pstrb      <= isStore ? sizeMask << addr[2:0] : '0;  // reads drive no strobes
            lane       <= addr[2:0];
            loadFunct3 <= funct3;
        end
    end

    assign psel    = (state != IDLE);
    assign penable = (state == ACCESS);
    assign done    = (state == ACCESS) && pready;

    always_comb begin
        laneData = prdata >> {lane, 3'b000};
        case (loadFunct3)
            F3_LB:   loadData = {{(`XLEN-8){laneData[7]}}, laneData[7:0]};
            F3_LH:   loadData = {{(`XLEN-16){laneData[15]}}, laneData[15:0]};
            F3_LW:   loadData = {{(`XLEN-32){laneData[31]}}, laneData[31:0]};
            F3_LBU:  loadData = {{(`XLEN-8){1'b0}}, laneData[7:0]};
            F3_LHU:  loadData = {{(`XLEN-16){1'b0}}, laneData[15:0]};
            F3_LWU:  loadData = {{(`XLEN-32){1'b0}}, laneData[31:0]};
            F3_LD:   loadData = laneData;
            default: loadData = laneData;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/execUnit.sv
`default_nettype none

`include "rvExec_defines.svh"

module execUnit
    import rvExecPkg::*;
(
    input  logic                clk,
    input  logic                rstN,
    input  logic                instValid,
    output logic                instReady,
    input  logic [`ILEN-1:0]    inst,
    input  logic [`XLEN-1:0]    pc,
    input  logic [`XLEN-1:0]    rs1Val,
    input  logic [`XLEN-1:0]    rs2Val,
    output logic                resValid,
    output logic                wbEn,
    output logic [4:0]          wbAddr,
    output logic [`XLEN-1:0]    wbData,
    output logic                pcTaken,
    output logic [`XLEN-1:0]    pcNext,
    output logic [`PADDR_W-1:0] paddr,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output logic [`XLEN-1:0]    pwdata,
    output logic [`XLEN/8-1:0]  pstrb,
    input  logic [`XLEN-1:0]    prdata,
    input  logic                pready
);

    opcode_t          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [4:0]       rd;
    logic [`XLEN-1:0] immI;
    logic [`XLEN-1:0] immS;
    logic [`XLEN-1:0] immB;
    logic [`XLEN-1:0] immU;
    logic [`XLEN-1:0] immJ;
    wbWord_t          wb;
    pcWord_t          target;
    logic             accept;
    logic             isMem;
    logic             isStore;
    logic             start;
    logic             memDone;
    logic [`XLEN-1:0] memAddr;
    logic [`XLEN-1:0] loadData;
    logic             busy;
    logic             memStore;
    logic [4:0]       memRd;

    immDecode u_immDecode (
        .inst  (inst),
        .opcode(opcode),
        .funct3(funct3),
        .funct7(funct7),
        .rd    (rd),
        .immI  (immI),
        .immS  (immS),
        .immB  (immB),
        .immU  (immU),
        .immJ  (immJ)
    );

    intAlu u_intAlu (
        .opcode(opcode),
        .funct3(funct3),
        .funct7(funct7),
        .pc    (pc),
        .rs1Val(rs1Val),
        .rs2Val(rs2Val),
        .immI  (immI),
        .immU  (immU),
        .wb    (wb)
    );

    branchUnit u_branchUnit (
        .opcode(opcode),
        .funct3(funct3),
        .pc    (pc),
        .rs1Val(rs1Val),
        .rs2Val(rs2Val),
        .immB  (immB),
        .immJ  (immJ),
        .immI  (immI),
        .target(target)
    );

    assign instReady = !busy;
    assign accept    = instValid && instReady;
    assign isStore   = (opcode == STORE);
    assign isMem     = (opcode == LOAD) || isStore;
    assign start     = accept && isMem;  // one cycle, busy drops ready
    assign memAddr   = rs1Val + (isStore ? immS : immI);

    lsuApb u_lsuApb (
        .clk      (clk),
        .rstN     (rstN),
        .start    (start),
        .isStore  (isStore),
        .funct3   (funct3),
        .addr     (memAddr),
        .storeData(rs2Val),
        .done     (memDone),
        .loadData (loadData),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .pstrb    (pstrb),
        .prdata   (prdata),
        .pready   (pready)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy     <= 1'b0;
            resValid <= 1'b0;
            wbEn     <= 1'b0;
            pcTaken  <= 1'b0;
        end else begin
            if (start) busy <= 1'b1;
            else if (memDone) busy <= 1'b0;
            resValid <= (accept && !isMem) || memDone;
            wbEn     <= (accept && !isMem && wb.en) || (memDone && !memStore);
            if (accept) pcTaken <= target.taken;  // never taken for memory ops
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            memRd    <= rd;  // inst may change while waiting
            memStore <= isStore;
        end
        if (accept) pcNext <= target.target;
        if (accept && !isMem) begin
            wbAddr <= rd;
            wbData <= wb.data;
        end else if (memDone) begin
            wbAddr <= memRd;
            wbData <= loadData;
        end
    end

endmodule

`default_nettype wire

// File: test/apbMemModel.sv
`default_nettype none

module apbMemModel (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [63:0] pwdata,
    input  logic [7:0]  pstrb,
    output logic [63:0] prdata,
    output logic        pready
);

    logic [63:0] mem [256];
    logic [1:0]  waitCnt;
    integer      seed;

    function automatic logic [7:0] fillByte(input logic [10:0] a);
        return 8'(a * 37 + (a >> 8) * 11) ^ 8'h5a;  // every address bit counts
    endfunction

    initial begin
        seed = 32'h696b_e87e;
        for (int w = 0; w < 256; w++) begin
            for (int b = 0; b < 8; b++) begin
                mem[w][8*b +: 8] = fillByte(11'(w * 8 + b));
            end
        end
    end

    assign prdata = mem[paddr[10:3]];

    always @(posedge clk or negedge rstN) begin
        logic [31:0] r;
        if (!rstN) begin
            pready  <= 1'b0;
            waitCnt <= '0;
        end else if (psel && !penable) begin
            r = $random(seed);
            waitCnt <= r[1:0];  // 0 to 3 wait states
            pready  <= (r[1:0] == 2'd0);
        end else if (psel && penable && !pready) begin
            waitCnt <= waitCnt - 1;
            pready  <= (waitCnt == 2'd1);
        end else if (psel && penable && pready) begin
            pready <= 1'b0;
            for (int i = 0; i < 8; i++) begin
                if (pwrite && pstrb[i]) mem[paddr[10:3]][8*i +: 8] <= pwdata[8*i +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: test/execUnitTb.sv
`default_nettype none

`include "rvExec_defines.svh"

module execUnitTb
    import rvExecPkg::*;
;

    localparam int NUM_TESTS = 120;

    typedef struct packed {
        logic             wbEn;
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
        logic             taken;
        logic [`XLEN-1:0] pcNext;
    } exp_t;

    logic clk;
    logic rstN;
    logic instValid;
    logic instReady;
    logic [`ILEN-1:0] inst;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] rs1Val;
    logic [`XLEN-1:0] rs2Val;
    logic resValid;
    logic wbEn;
    logic [4:0] wbAddr;
    logic [`XLEN-1:0] wbData;
    logic pcTaken;
    logic [`XLEN-1:0] pcNext;
    logic [`PADDR_W-1:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [`XLEN-1:0] pwdata;
    logic [`XLEN/8-1:0] pstrb;
    logic [`XLEN-1:0] prdata;
    logic pready;

    integer seed = 32'h696b_e87e;
    int mismatches = 0;
    int assertFails = 0;
    exp_t expQ [$];
    logic [31:0] addrQ [$];
    logic writeQ [$];
    logic [7:0] strbQ [$];
    logic [63:0] wdataQ [$];
    logic [7:0] shadow [2048];
    logic isMemIn;

    execUnit u_execUnit (.*);

    apbMemModel u_apbMemModel (
        .clk(clk), .rstN(rstN), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * 40 * 20);
        $display("watchdog expired before all results arrived");
        $display("Something failed");
        $finish;
    end

    assign isMemIn = (inst[6:0] == LOAD) || (inst[6:0] == STORE);

    // result one cycle after a non-memory accept
    assert property (@(posedge clk) disable iff (!rstN)
        (instValid && instReady && !isMemIn) |=> resValid)
    else begin
        assertFails++;
        $display("resValid missing one cycle after accept");
    end

    assert property (@(posedge clk) disable iff (!rstN) $rose(penable) |-> $past(psel))
    else begin
        assertFails++;
        $display("penable rose without a setup cycle");
    end

    assert property (@(posedge clk) disable iff (!rstN)
        (psel && penable && !pready) |=> psel && penable && $stable(paddr)
        && $stable(pwrite) && $stable(pwdata) && $stable(pstrb))
    else begin
        assertFails++;
        $display("APB request changed during wait state");
    end

    assert property (@(posedge clk) disable iff (!rstN)
        (instValid && instReady && isMemIn) |=> !instReady)
    else begin
        assertFails++;
        $display("instReady high after memory accept");
    end

    assert property (@(posedge clk) disable iff (!rstN) $rose(instReady) |-> resValid)
    else begin
        assertFails++;
        $display("instReady returned without resValid");
    end

    function automatic logic [7:0] fillByte(input logic [10:0] a);
        return 8'(a * 37 + (a >> 8) * 11) ^ 8'h5a;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    always @(negedge clk) begin
        exp_t e;
        logic [63:0] m;
        if (rstN && resValid) begin
            if (expQ.size() == 0) begin
                mismatches++;
                $display("resValid with no instruction outstanding");
            end else begin
                e = expQ.pop_front();
                compare("wbEn", wbEn, e.wbEn);
                if (e.wbEn) compare("wbAddr", wbAddr, e.rd);
                if (e.wbEn) compare("wbData", wbData, e.data);
                compare("pcTaken", pcTaken, e.taken);
                compare("pcNext", pcNext, e.pcNext);
            end
        end
        if (rstN && psel && penable && pready) begin
            if (addrQ.size() == 0) begin
                mismatches++;
                $display("APB transfer with no memory instruction outstanding");
            end else begin
                compare("paddr", paddr, addrQ[0]);
                compare("pwrite", pwrite, writeQ[0]);
                if (writeQ[0]) begin
                    for (int i = 0; i < 8; i++) m[8*i +: 8] = {8{strbQ[0][i]}};
                    compare("pstrb", pstrb, strbQ[0]);
                    compare("pwdata", pwdata & m, wdataQ[0] & m);  // only strobed lanes
                    void'(strbQ.pop_front());
                    void'(wdataQ.pop_front());
                end
                void'(addrQ.pop_front());
                void'(writeQ.pop_front());
            end
        end
    end

    task automatic send(input logic [31:0] in, input logic [63:0] p, input logic [63:0] a,
                        input logic [63:0] b, input exp_t e);
        logic rdy;
        inst      <= in;
        pc        <= p;
        rs1Val    <= a;
        rs2Val    <= b;
        instValid <= 1'b1;
        expQ.push_back(e);
        rdy = 1'b0;
        while (!rdy) begin
            @(negedge clk);
            rdy = instReady;
            @(posedge clk);
        end
    endtask

    function automatic logic [63:0] aluRef(input int kind, input logic word,
                                           input logic [63:0] a, input logic [63:0] b);
        logic [31:0] a32;
        logic [31:0] r32;
        a32 = a[31:0];
        if (!word) begin
            case (kind)
                0: return a + b;
                1: return a - b;
                2: return a << b[5:0];
                3: return {63'd0, $signed(a) < $signed(b)};
                4: return {63'd0, a < b};
                5: return a ^ b;
                6: return a >> b[5:0];
                7: return $signed(a) >>> b[5:0];
                8: return a | b;
                9: return a & b;
                default: return a * b;
            endcase
        end
        case (kind)
            0: r32 = a32 + b[31:0];
            1: r32 = a32 - b[31:0];
            2: r32 = a32 << b[4:0];
            6: r32 = a32 >> b[4:0];
            7: r32 = $signed(a32) >>> b[4:0];
            default: r32 = a32 * b[31:0];
        endcase
        return {{32{r32[31]}}, r32};
    endfunction

    initial begin
        logic [2:0] f3Tab [11];
        logic [2:0] brTab [6];
        int kind;
        int form;
        logic [6:0] f7;
        logic [6:0] op;
        logic [11:0] imm12;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] p;
        logic [63:0] addr;
        logic [4:0] rd;
        logic [2:0] f3;
        logic tk;
        int size;
        exp_t e;

        f3Tab = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7, 0};
        brTab = '{0, 1, 4, 5, 6, 7};
        for (int i = 0; i < 2048; i++) shadow[i] = fillByte(11'(i));
        rstN = 1'b0;
        instValid = 1'b0;
        inst = '0;
        pc = '0;
        rs1Val = '0;
        rs2Val = '0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        compare("resValid", resValid, 0);
        compare("wbEn", wbEn, 0);
        compare("pcTaken", pcTaken, 0);
        compare("psel", psel, 0);
        compare("penable", penable, 0);
        compare("instReady", instReady, 1);
        @(posedge clk);

        // register-register and register-immediate ops
        for (int t = 0; t < 40; t++) begin
            do begin
                kind = (t == 0 || t == 1) ? 10 : (t == 2 || t == 3) ? 7
                     : $unsigned($random(seed)) % 11;
                form = (t < 4) ? ((t == 1) ? 2 : (t == 3) ? 3 : 0) : $unsigned($random(seed)) % 4;
            end while ((form[0] && (kind == 1 || kind == 10))
                       || (form >= 2 && kind inside {3, 4, 5, 8, 9}));
            f7 = (kind == 1 || kind == 7) ? 7'b0100000 : (kind == 10) ? 7'b0000001 : 7'b0;
            op = (form == 0) ? OP : (form == 1) ? OP_IMM : (form == 2) ? OP_32 : OP_IMM_32;
            a = {$random(seed), $random(seed)};
            b = {$random(seed), $random(seed)};
            imm12 = $random(seed);
            if (kind == 2 || kind == 6 || kind == 7) begin
                imm12 = (form == 3) ? {f7, imm12[4:0]} : {f7[6:1], imm12[5:0]};
            end
            rd = $random(seed);
            e.wbEn = 1'b1;
            e.rd = rd;
            e.data = aluRef(kind, form >= 2, a, form[0] ? {{52{imm12[11]}}, imm12} : b);
            p = {$random(seed), $random(seed)} & ~64'd3;
            e.taken = 1'b0;
            e.pcNext = p + 4;
            if (form[0]) send({imm12, 5'd1, f3Tab[kind], rd, op}, p, a, b, e);
            else send({f7, 5'd2, 5'd1, f3Tab[kind], rd, op}, p, a, b, e);
        end

        // branches, taken and not
        for (int t = 0; t < 24; t++) begin
            f3 = brTab[t % 6];
            a = {$random(seed), $random(seed)};
            b = t[3] ? a : t[4] ? a + 1 : {$random(seed), $random(seed)};  // equal, then rs2 above
            imm12 = $random(seed);  // imm[12:1]
            p = {$random(seed), $random(seed)} & ~64'd3;
            case (f3)
                0: tk = a == b;
                1: tk = a != b;
                4: tk = $signed(a) < $signed(b);
                5: tk = $signed(a) >= $signed(b);
                6: tk = a < b;
                default: tk = a >= b;
            endcase
            e.wbEn = 1'b0;
            e.rd = 0;
            e.data = 0;
            e.taken = tk;
            e.pcNext = tk ? p + {{51{imm12[11]}}, imm12, 1'b0} : p + 4;
            send({imm12[11], imm12[9:4], 5'd2, 5'd1, f3, imm12[3:0], imm12[10], BRANCH},
                 p, a, b, e);
        end

        // JAL, JALR, LUI, AUIPC
        for (int t = 0; t < 16; t++) begin
            a = {$random(seed), $random(seed)};
            b = {$random(seed), $random(seed)};  // b[19:0] as raw immediate
            p = {$random(seed), $random(seed)} & ~64'd3;
            rd = $random(seed);
            e.wbEn = 1'b1;
            e.rd = rd;
            e.taken = t < 8;
            e.pcNext = p + 4;
            e.data = p + 4;
            case (t / 4)
                0: begin
                    e.pcNext = p + {{43{b[19]}}, b[19:0], 1'b0};
                    send({b[19], b[9:0], b[10], b[18:11], rd, JAL}, p, a, 0, e);
                end
                1: begin
                    e.pcNext = (a + {{52{b[11]}}, b[11:0]}) & ~64'd1;
                    send({b[11:0], 5'd1, 3'b000, rd, JALR}, p, a, 0, e);
                end
                2: begin
                    e.data = {{32{b[19]}}, b[19:0], 12'd0};
                    send({b[19:0], rd, LUI}, p, a, 0, e);
                end
                default: begin
                    e.data = p + {{32{b[19]}}, b[19:0], 12'd0};
                    send({b[19:0], rd, AUIPC}, p, a, 0, e);
                end
            endcase
        end

        // stores then loads, naturally aligned
        for (int t = 0; t < 40; t++) begin
            f3 = (t < 16) ? 3'(t % 4) : (t < 23) ? 3'(t - 16)
               : 3'($unsigned($random(seed)) % 7);
            size = 1 << f3[1:0];
            addr = 1024 + ($unsigned($random(seed)) % 64) * 8
                 + (($random(seed) & 7) & ~(size - 1));
            imm12 = {{3{imm12[8]}}, 9'($random(seed))};
            a = addr - {{52{imm12[11]}}, imm12};
            b = {$random(seed), $random(seed)};
            p = {$random(seed), $random(seed)} & ~64'd3;
            rd = $random(seed);
            e.rd = rd;
            e.taken = 1'b0;
            e.pcNext = p + 4;
            e.data = 0;
            addrQ.push_back(addr[31:0]);
            writeQ.push_back(t < 16);
            if (t < 16) begin
                e.wbEn = 1'b0;
                for (int i = 0; i < size; i++) shadow[addr + i] = b[8*i +: 8];
                strbQ.push_back(8'((1 << size) - 1) << addr[2:0]);
                wdataQ.push_back(b << (addr[2:0] * 8));
                send({imm12[11:5], 5'd2, 5'd1, f3, imm12[4:0], STORE}, p, a, b, e);
            end else begin
                e.wbEn = 1'b1;
                for (int i = 0; i < 8; i++) begin
                    e.data[8*i +: 8] = (i < size) ? shadow[addr + i]
                                     : (f3[2] ? 8'h00 : {8{e.data[8*size-1]}});
                end
                send({imm12, 5'd1, f3, rd, LOAD}, p, a, b, e);
            end
        end

        instValid <= 1'b0;
        while (expQ.size() != 0) @(negedge clk);
        repeat (4) @(posedge clk);
        $display("errors: %0d mismatches, %0d assertion failures", mismatches, assertFails);
        if (mismatches == 0 && assertFails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rvExec.f
+incdir+hdl
hdl/rvExecPkg.sv
hdl/immDecode.sv
hdl/keyMux.sv
hdl/intAlu.sv
hdl/branchUnit.sv
hdl/lsuApb.sv
hdl/execUnit.sv
test/apbMemModel.sv
test/execUnitTb.sv

// File: Bender.yml
package:
  name: rvExec

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rvExecPkg.sv
      - hdl/immDecode.sv
      - hdl/keyMux.sv
      - hdl/intAlu.sv
      - hdl/branchUnit.sv
      - hdl/lsuApb.sv
      - hdl/execUnit.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/apbMemModel.sv
      - test/execUnitTb.sv
